/* hdl/t07_mmio_config.svh */
`ifndef T07_MMIO_CONFIG_SVH
`define T07_MMIO_CONFIG_SVH

// upper bounds of the memory map windows, inclusive unless noted
`define T07_INSTR_TOP 32'd1024  // last instruction address
`define T07_REG_TOP   32'd1056  // last peripheral register address
`define T07_DATA_TOP  32'd1792  // last data address
`define T07_TFT_END   32'd2048  // first address past the display window

// top byte placed on every off-chip memory address
`define T07_MEM_PREFIX 8'h33

// peripheral register file depth
`define T07_REG_COUNT 32

`endif

/* hdl/t07_mmio_pkg.sv */
package t07_mmio_pkg;

    // operation presented by the cpu core
    typedef enum logic [1:0] {
        op_write = 2'b01,  // store to a mapped address
        op_read  = 2'b10,  // load from a mapped address
        op_idle  = 2'b11   // nothing requested
    } mem_op_e;

    // operation sent on to the instruction/data memory
    typedef enum logic [1:0] {
        ext_read_instr = 2'b00,  // instruction fetch
        ext_write      = 2'b01,  // data store
        ext_read_data  = 2'b10,  // data load
        ext_idle       = 2'b11   // memory not addressed
    } ext_op_e;

    // address windows of the memory map
    typedef enum logic [2:0] {
        rgn_instr,  // 0 .. 1024
        rgn_reg,    // 1025 .. 1056
        rgn_data,   // 1057 .. 1792
        rgn_tft,    // 1793 .. 2047
        rgn_none    // anything above
    } region_e;

    // wishbone master sequencing
    typedef enum logic [1:0] {
        wb_idle,     // waiting for a request
        wb_bus,      // cyc/stb out, waiting for ack
        wb_done,     // result valid for one cycle
        wb_release   // hold off until the request drops
    } wb_state_e;

endpackage

/* hdl/t07_mmio.sv */
`include "t07_mmio_config.svh"

module t07_mmio (
    input  t07_mmio_pkg::mem_op_e op,           // cpu operation
    input  logic [31:0]           addr,         // cpu address, pc on fetches
    input  logic [31:0]           wdata,        // store data from cpu
    input  logic                  fetch_read,   // instruction fetch strobe
    input  logic [31:0]           mem_rdata,    // data captured by the bus master
    input  logic                  mem_busy,     // bus master still working
    input  logic [31:0]           reg_rdata,    // peripheral register data
    input  logic                  reg_ack,      // peripheral read answered
    input  logic                  tft_ack,      // display accepted the write
    output logic                  busy,         // stall for the cpu
    output logic [31:0]           rdata,        // load result
    output logic [31:0]           instruction,  // fetched instruction
    output t07_mmio_pkg::ext_op_e ext_op,       // request to the bus master
    output logic [31:0]           ext_addr,
    output logic [31:0]           ext_wdata,
    output logic                  reg_rd,       // peripheral register read
    output logic [4:0]            reg_addr,
    output logic                  tft_wr,       // display write strobe
    output logic [31:0]           tft_addr,
    output logic [31:0]           tft_wdata
);

    t07_mmio_pkg::region_e region;  // window the address falls in
    logic                  is_read;  // load requested
    logic                  is_write;  // store requested
    logic [31:0]           mem_addr;  // address in off-chip memory space

    assign is_read  = (op == t07_mmio_pkg::op_read);
    assign is_write = (op == t07_mmio_pkg::op_write);
    assign mem_addr = {`T07_MEM_PREFIX, addr[23:0]};  // memory lives behind the prefix byte

    always_comb begin  // window decode, boundaries are inclusive tops
        if (addr <= `T07_INSTR_TOP) begin
            region = t07_mmio_pkg::rgn_instr;
        end else if (addr <= `T07_REG_TOP) begin
            region = t07_mmio_pkg::rgn_reg;
        end else if (addr <= `T07_DATA_TOP) begin
            region = t07_mmio_pkg::rgn_data;
        end else if (addr < `T07_TFT_END) begin
            region = t07_mmio_pkg::rgn_tft;
        end else begin
            region = t07_mmio_pkg::rgn_none;
        end
    end

    always_comb begin
        busy        = 1'b0;  // unmapped never stalls
        rdata       = 32'd0;
        instruction = 32'd0;
        ext_op      = t07_mmio_pkg::ext_idle;
        ext_addr    = 32'd0;
        ext_wdata   = 32'd0;
        reg_rd      = 1'b0;
        reg_addr    = 5'd0;
        tft_wr      = 1'b0;
        tft_addr    = 32'd0;
        tft_wdata   = 32'd0;

        case (region)
            t07_mmio_pkg::rgn_instr: begin
                if (fetch_read) begin  // only fetches reach the instruction area
                    ext_op      = t07_mmio_pkg::ext_read_instr;
                    ext_addr    = mem_addr;
                    busy        = mem_busy;
                    instruction = mem_rdata;  // goes to fetch, not to rdata
                end
            end
            t07_mmio_pkg::rgn_reg: begin
                if (is_read) begin  // window is read-only for the cpu
                    reg_rd   = 1'b1;
                    reg_addr = addr[4:0] - 5'(`T07_INSTR_TOP + 1);  // 1025 is register 0
                    busy     = !reg_ack;
                    rdata    = reg_rdata;
                end
            end
            t07_mmio_pkg::rgn_data: begin
                if (is_write) begin
                    ext_op    = t07_mmio_pkg::ext_write;
                    ext_addr  = mem_addr;
                    ext_wdata = wdata;
                    busy      = mem_busy;
                end else if (is_read) begin
                    ext_op   = t07_mmio_pkg::ext_read_data;
                    ext_addr = mem_addr;
                    busy     = mem_busy;
                    rdata    = mem_rdata;
                end
            end
            t07_mmio_pkg::rgn_tft: begin
                if (is_write) begin  // display cannot be read back
                    tft_wr    = 1'b1;
                    tft_addr  = addr;  // display decodes the full address
                    tft_wdata = wdata;
                    busy      = !tft_ack;  // held until the display answers
                end
            end
            default: ;  // out of map, everything stays idle
        endcase
    end

endmodule

/* hdl/t07_wb_master.sv */
module t07_wb_master (
    input  logic                  clk,
    input  logic                  rst,
    input  t07_mmio_pkg::ext_op_e ext_op,     // request from the decoder
    input  logic [31:0]           ext_addr,
    input  logic [31:0]           ext_wdata,
    input  logic                  wb_ack,     // slave ends the cycle
    input  logic [31:0]           wb_dat_r,
    output logic                  mem_busy,   // request not yet finished
    output logic [31:0]           mem_rdata,  // read data captured at ack
    output logic                  wb_cyc,
    output logic                  wb_stb,
    output logic                  wb_we,
    output logic [31:0]           wb_adr,
    output logic [31:0]           wb_dat_w
);

    t07_mmio_pkg::wb_state_e state;
    logic                    req;    // decoder is presenting an operation
    logic                    start;  // launch a bus cycle on this edge

    assign req   = (ext_op != t07_mmio_pkg::ext_idle);
    assign start = (state == t07_mmio_pkg::wb_idle) && req;

    // busy from the first request cycle, low from wb_done on
    assign mem_busy = start || (state == t07_mmio_pkg::wb_bus);

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= t07_mmio_pkg::wb_idle;
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
        end else begin
            case (state)
                t07_mmio_pkg::wb_idle: begin
                    if (req) begin  // cyc and stb rise together
                        state  <= t07_mmio_pkg::wb_bus;
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                    end
                end
                t07_mmio_pkg::wb_bus: begin
                    if (wb_ack) begin  // both drop on the edge after ack
                        state  <= t07_mmio_pkg::wb_done;
                        wb_cyc <= 1'b0;
                        wb_stb <= 1'b0;
                    end
                end
                t07_mmio_pkg::wb_done: begin
                    state <= t07_mmio_pkg::wb_release;  // result seen by cpu this cycle
                end
                t07_mmio_pkg::wb_release: begin
                    if (!req) begin  // a held request must not run twice
                        state <= t07_mmio_pkg::wb_idle;
                    end
                end
                default: state <= t07_mmio_pkg::wb_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin  // address and data held for the whole cycle
            wb_we    <= (ext_op == t07_mmio_pkg::ext_write);
            wb_adr   <= ext_addr;
            wb_dat_w <= ext_wdata;
        end
        if ((state == t07_mmio_pkg::wb_bus) && wb_ack && !wb_we) begin
            mem_rdata <= wb_dat_r;  // fetch or data load
        end
    end

endmodule

/* hdl/t07_ext_regs.sv */
`include "t07_mmio_config.svh"

module t07_ext_regs (
    input  logic        clk,
    input  logic        rst,
    input  logic        reg_rd,     // cpu read request, held until ack
    input  logic [4:0]  reg_addr,
    input  logic        dev_wr,     // outside device write strobe
    input  logic [4:0]  dev_addr,
    input  logic [31:0] dev_wdata,
    output logic [31:0] reg_rdata,  // registered read data
    output logic        reg_ack     // one cycle after reg_rd
);

    logic [31:0] regs [`T07_REG_COUNT];  // peripheral registers
    logic        bypass;  // device writes the word being read

    assign bypass = dev_wr && (dev_addr == reg_addr);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `T07_REG_COUNT; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (dev_wr) begin
            regs[dev_addr] <= dev_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            reg_ack <= 1'b0;
        end else begin
            reg_ack <= reg_rd;  // stays up while the read is held
        end
    end

    always_ff @(posedge clk) begin
        if (reg_rd) begin
            if (bypass) begin
                reg_rdata <= dev_wdata;  // new value wins over the stored one
            end else begin
                reg_rdata <= regs[reg_addr];
            end
        end
    end

endmodule

/* hdl/t07_mmio_top.sv */
module t07_mmio_top (
    input  logic                  clk,
    input  logic                  rst,
    input  t07_mmio_pkg::mem_op_e op,           // cpu side
    input  logic [31:0]           addr,
    input  logic [31:0]           wdata,
    input  logic                  fetch_read,
    output logic                  busy,
    output logic [31:0]           rdata,
    output logic [31:0]           instruction,
    output logic                  wb_cyc,       // wishbone to memory
    output logic                  wb_stb,
    output logic                  wb_we,
    output logic [31:0]           wb_adr,
    output logic [31:0]           wb_dat_w,
    input  logic                  wb_ack,
    input  logic [31:0]           wb_dat_r,
    input  logic                  dev_wr,       // peripheral device side
    input  logic [4:0]            dev_addr,
    input  logic [31:0]           dev_wdata,
    output logic                  tft_wr,       // display side
    output logic [31:0]           tft_addr,
    output logic [31:0]           tft_wdata,
    input  logic                  tft_ack
);

    t07_mmio_pkg::ext_op_e ext_op;     // decoder to bus master
    logic [31:0]           ext_addr;
    logic [31:0]           ext_wdata;
    logic [31:0]           mem_rdata;  // bus master to decoder
    logic                  mem_busy;
    logic                  reg_rd;     // decoder to register file
    logic [4:0]            reg_addr;
    logic [31:0]           reg_rdata;  // register file to decoder
    logic                  reg_ack;

    t07_mmio t07_mmio_inst (
        .op          (op),
        .addr        (addr),
        .wdata       (wdata),
        .fetch_read  (fetch_read),
        .mem_rdata   (mem_rdata),
        .mem_busy    (mem_busy),
        .reg_rdata   (reg_rdata),
        .reg_ack     (reg_ack),
        .tft_ack     (tft_ack),
        .busy        (busy),
        .rdata       (rdata),
        .instruction (instruction),
        .ext_op      (ext_op),
        .ext_addr    (ext_addr),
        .ext_wdata   (ext_wdata),
        .reg_rd      (reg_rd),
        .reg_addr    (reg_addr),
        .tft_wr      (tft_wr),
        .tft_addr    (tft_addr),
        .tft_wdata   (tft_wdata)
    );

    t07_wb_master t07_wb_master_inst (
        .clk       (clk),
        .rst       (rst),
        .ext_op    (ext_op),
        .ext_addr  (ext_addr),
        .ext_wdata (ext_wdata),
        .wb_ack    (wb_ack),
        .wb_dat_r  (wb_dat_r),
        .mem_busy  (mem_busy),
        .mem_rdata (mem_rdata),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w)
    );

    t07_ext_regs t07_ext_regs_inst (
        .clk       (clk),
        .rst       (rst),
        .reg_rd    (reg_rd),
        .reg_addr  (reg_addr),
        .dev_wr    (dev_wr),
        .dev_addr  (dev_addr),
        .dev_wdata (dev_wdata),
        .reg_rdata (reg_rdata),
        .reg_ack   (reg_ack)
    );

endmodule

/* verification/t07_wb_mem_model.sv */
module t07_wb_mem_model (
    input  logic        clk,
    input  logic        rst,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [31:0] wb_adr,    // low byte selects the word
    input  logic [31:0] wb_dat_w,
    output logic        wb_ack,
    output logic [31:0] wb_dat_r
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0] mem [256];
    logic [31:0] lcg_state;    // wait state source
    logic [1:0]  wait_left;    // cycles still to hold off ack
    logic [1:0]  wait_now;     // wait states still due in this cycle
    logic        active;       // current cycle already counted
    logic [31:0] last_wr_adr;  // full address of the latest store

    assign wait_now = active ? wait_left : lcg_state[17:16];  // fresh draw on the first stb cycle

    initial begin
        wb_ack   = 1'b0;
        wb_dat_r = 32'd0;
    end

    always @(posedge clk) begin
        if (rst) begin
            wb_ack    <= 1'b0;
            active    <= 1'b0;
            lcg_state <= 32'd660;
        end else if (wb_ack) begin
            wb_ack <= 1'b0;  // master ends the cycle on this edge
            active <= 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (!active) begin
                active    <= 1'b1;
                lcg_state <= lcg_state * 32'd1103515245 + 32'd12345;
            end
            if (wait_now != 2'd0) begin  // 0 to 3 wait states
                wait_left <= wait_now - 2'd1;
            end else begin
                wb_ack   <= 1'b1;
                wb_dat_r <= mem[wb_adr[7:0]];
                if (wb_we) begin
                    mem[wb_adr[7:0]] <= wb_dat_w;
                    last_wr_adr      <= wb_adr;
                end
            end
        end
    end

endmodule

/* verification/t07_mmio_assert.sv */
module t07_mmio_assert (
    input logic                  clk,
    input logic                  rst,
    input logic                  wb_cyc,
    input logic                  wb_stb,
    input logic                  wb_ack,
    input logic [31:0]           wb_adr,
    input t07_mmio_pkg::ext_op_e ext_op,   // decoder to bus master
    input logic                  reg_rd,   // decoder to register file
    input logic                  reg_ack,
    input logic                  tft_wr,
    input logic                  busy      // stall seen by the cpu
);
    timeunit 1ns;
    timeprecision 1ps;

    stb_within_cyc: assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_cyc)
        else $error("wb_stb high while wb_cyc is low");
    cycle_held: assert property (@(posedge clk) disable iff (rst)
        wb_cyc && !wb_ack |=> wb_cyc && wb_stb && $stable(wb_adr))
        else $error("wishbone cycle dropped or address changed before ack");
    quiet_after_reset: assert property (@(posedge clk) rst |=> !wb_stb)
        else $error("wb_stb high in the cycle after reset");
    single_target: assert property (@(posedge clk) disable iff (rst)
        $onehot0({ext_op != t07_mmio_pkg::ext_idle, reg_rd, tft_wr}))
        else $error("more than one target enabled by the decoder");
    reg_ack_delay: assert property (@(posedge clk) disable iff (rst)
        reg_rd && !reg_ack |=> reg_ack && !busy)  // register read done one cycle later
        else $error("register read not answered one cycle after reg_rd");

endmodule

bind t07_mmio_top t07_mmio_assert t07_mmio_assert_inst (.*);

/* verification/t07_mmio_tb.sv */
`include "t07_mmio_config.svh"

module t07_mmio_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 3000;  // about ten times the directed run

    logic                  clk, rst, fetch_read, busy, dev_wr, tft_wr, tft_ack;
    logic                  wb_cyc, wb_stb, wb_we, wb_ack;
    logic [4:0]            dev_addr;
    logic [31:0]           addr, wdata, rdata, instruction, dev_wdata, tft_addr, tft_wdata;
    logic [31:0]           wb_adr, wb_dat_w, wb_dat_r, got_rdata, got_instr;
    t07_mmio_pkg::mem_op_e op;
    logic [2:0]            got_en;    // decoder target enables at completion
    int                    got_wait;  // cycles busy stayed high
    logic [31:0]           seed;      // lcg state for random traffic
    int                    cycle_count = 0;

    t07_mmio_top t07_mmio_top_inst (.*);
    t07_wb_mem_model mem_model_inst (.*);  // wishbone slave, random wait states

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
            $display("Verification failed");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic expect_equal(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED at %0d ns: %s = 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
            $display("Verification failed");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic drive_request(input t07_mmio_pkg::mem_op_e req_op, input logic [31:0] req_addr,
                                 input logic [31:0] req_wdata, input logic req_fetch);
        @(posedge clk);
        #1;  // inputs move just after the edge
        op         = req_op;
        addr       = req_addr;
        wdata      = req_wdata;
        fetch_read = req_fetch;
    endtask

    // request, wait for busy low, sample results, then one idle cycle
    task automatic cpu_access(input t07_mmio_pkg::mem_op_e req_op, input logic [31:0] req_addr,
                              input logic [31:0] req_wdata, input logic req_fetch);
        drive_request(req_op, req_addr, req_wdata, req_fetch);
        got_wait = 0;
        @(negedge clk);  // outputs settled mid cycle
        while (busy) begin
            @(negedge clk);
            got_wait++;
        end
        got_rdata = rdata;
        got_instr = instruction;
        got_en    = {t07_mmio_top_inst.ext_op != t07_mmio_pkg::ext_idle,
                     t07_mmio_top_inst.reg_rd, tft_wr};
        drive_request(t07_mmio_pkg::op_idle, 32'd0, 32'd0, 1'b0);
    endtask

    task automatic test_register_read();
        @(posedge clk);
        #1;
        dev_wr    = 1'b1;  // device fills register 7
        dev_addr  = 5'd7;
        dev_wdata = 32'h1234_5678;
        @(posedge clk);
        #1;
        dev_wr = 1'b0;
        cpu_access(t07_mmio_pkg::op_read, 32'd1032, 32'd0, 1'b0);  // 1025 + 7
        expect_equal("rdata", got_rdata, 32'h1234_5678);
        expect_equal("register wait cycles", got_wait, 32'd1);
    endtask

    task automatic test_data_write_read();
        cpu_access(t07_mmio_pkg::op_write, 32'd1100, 32'hcafe_0101, 1'b0);
        expect_equal("stored wb_adr", mem_model_inst.last_wr_adr, {`T07_MEM_PREFIX, 24'd1100});
        cpu_access(t07_mmio_pkg::op_read, 32'd1100, 32'd0, 1'b0);
        expect_equal("rdata", got_rdata, 32'hcafe_0101);
    endtask

    task automatic test_fetch();
        mem_model_inst.mem[0] = 32'h0bad_f00d;  // word behind address 1024
        cpu_access(t07_mmio_pkg::op_read, `T07_INSTR_TOP, 32'd0, 1'b1);
        expect_equal("instruction", got_instr, 32'h0bad_f00d);
        expect_equal("rdata", got_rdata, 32'd0);
    endtask

    task automatic test_tft_write();
        drive_request(t07_mmio_pkg::op_write, 32'd1800, 32'h00ff_8800, 1'b0);
        repeat (3) begin  // display has not answered yet
            @(negedge clk);
            expect_equal("busy", busy, 32'd1);
        end
        expect_equal("tft_wr", tft_wr, 32'd1);
        expect_equal("tft_addr", tft_addr, 32'd1800);
        expect_equal("tft_wdata", tft_wdata, 32'h00ff_8800);
        @(posedge clk);
        #1;
        tft_ack = 1'b1;
        @(negedge clk);
        expect_equal("busy", busy, 32'd0);
        drive_request(t07_mmio_pkg::op_idle, 32'd0, 32'd0, 1'b0);
        tft_ack = 1'b0;
    endtask

    task automatic check_unmapped(input t07_mmio_pkg::mem_op_e req_op, input logic [31:0] req_addr);
        cpu_access(req_op, req_addr, 32'h5a5a_a5a5, 1'b0);
        expect_equal("unmapped wait cycles", got_wait, 32'd0);
        expect_equal("target enables", got_en, 32'd0);
        expect_equal("rdata", got_rdata, 32'd0);
    endtask

    task automatic test_random_traffic();
        logic [31:0] addrs [20];
        logic [31:0] shadow [int];  // expected memory contents
        for (int i = 0; i < 20; i++) begin
            seed     = lcg_next(seed);
            addrs[i] = 32'd1110 + (seed[23:8] % 140);  // stays inside the data area
            seed     = lcg_next(seed);
            shadow[addrs[i]] = seed;
            cpu_access(t07_mmio_pkg::op_write, addrs[i], seed, 1'b0);
        end
        for (int i = 0; i < 20; i++) begin
            cpu_access(t07_mmio_pkg::op_read, addrs[i], 32'd0, 1'b0);
            expect_equal("rdata", got_rdata, shadow[addrs[i]]);
        end
    endtask

    initial begin
        rst        = 1'b1;
        op         = t07_mmio_pkg::op_idle;
        addr       = 32'd0;
        wdata      = 32'd0;
        fetch_read = 1'b0;
        dev_wr     = 1'b0;
        dev_addr   = 5'd0;
        dev_wdata  = 32'd0;
        tft_ack    = 1'b0;
        seed       = 32'd660;
        repeat (4) @(posedge clk);  // reset held four cycles
        #1;
        rst = 1'b0;
        test_register_read();
        test_data_write_read();
        test_fetch();
        test_tft_write();
        check_unmapped(t07_mmio_pkg::op_read, 32'd1900);   // display window is write-only
        check_unmapped(t07_mmio_pkg::op_write, 32'd1030);  // register window is read-only
        check_unmapped(t07_mmio_pkg::op_read, `T07_TFT_END);
        test_random_traffic();
        $display("Verification passed");
        $finish;
    end

endmodule

/* t07_mmio_top.f */
+incdir+hdl
hdl/t07_mmio_pkg.sv
hdl/t07_mmio.sv
hdl/t07_wb_master.sv
hdl/t07_ext_regs.sv
hdl/t07_mmio_top.sv
verification/t07_wb_mem_model.sv
verification/t07_mmio_assert.sv
verification/t07_mmio_tb.sv
